// ==== Makefile ====
TOP := taylor_unit_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== hdl/dsp_mac_slice.sv ====
// Behavioral multiply-accumulate slice in the style of an FPGA DSP block
// Operands registered, then product M, then accumulator P = Z + X

`timescale 1ns/1ps

module dsp_mac_slice import taylor_pkg::*; (
    input  logic     reset,
    input  logic     clk,
    input  dsp_in_t  dsp_in,
    output dsp_out_t dsp_out
);

    // Input stage
    fix18_t   a_reg;
    fix18_t   b_reg;
    xin_sel_e xin_d1;
    zin_sel_e zin_d1;

    // Product stage with the selects delayed alongside M
    logic signed [35:0] m_reg;
    xin_sel_e           xin_d2;
    zin_sel_e           zin_d2;

    // Accumulator stage
    logic signed [47:0] p_reg;
    logic signed [47:0] x_mux;
    logic signed [47:0] z_mux;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            a_reg  <= FIX_ZERO;
            b_reg  <= FIX_ZERO;
            xin_d1 <= XIN_ZERO;
            zin_d1 <= ZIN_ZERO;
            m_reg  <= '0;
            xin_d2 <= XIN_ZERO;
            zin_d2 <= ZIN_ZERO;
            p_reg  <= '0;
        end else begin
            a_reg  <= dsp_in.a;
            b_reg  <= dsp_in.b;
            xin_d1 <= dsp_in.xin_sel;
            zin_d1 <= dsp_in.zin_sel;

            m_reg  <= a_reg * b_reg;
            xin_d2 <= xin_d1;
            zin_d2 <= zin_d1;

            p_reg  <= z_mux + x_mux;
        end
    end

    // X picks up the sign-extended product
    always_comb begin
        if (xin_d2 == XIN_MULT) begin
            x_mux = {{12{m_reg[35]}}, m_reg};
        end else begin
            x_mux = '0;
        end
    end

    // Z feeds back the accumulator
    always_comb begin
        if (zin_d2 == ZIN_POUT) begin
            z_mux = p_reg;
        end else begin
            z_mux = '0;
        end
    end

    assign dsp_out.m = m_reg;
    assign dsp_out.p = p_reg;

endmodule

// ==== hdl/taylor_coef_rom.sv ====
// Derivative-at-zero coefficient table for the five series functions
// Purely combinational; the sequencer addresses it with the term index

`timescale 1ns/1ps

module taylor_coef_rom import taylor_pkg::*; (
    input  func_sel_e func_sel,
    input  term_idx_t idx,
    output fix18_t    coef
);

    always_comb begin
        coef = FIX_ZERO;
        case (func_sel)
            // 0, 1, 0, -1 repeating
            FUNC_SIN: begin
                case (idx[1:0])
                    2'd1:    coef = FIX_ONE;
                    2'd3:    coef = FIX_NEG_ONE;
                    default: coef = FIX_ZERO;
                endcase
            end

            // 1, 0, -1, 0 repeating
            FUNC_COS: begin
                case (idx[1:0])
                    2'd0:    coef = FIX_ONE;
                    2'd2:    coef = FIX_NEG_ONE;
                    default: coef = FIX_ZERO;
                endcase
            end

            FUNC_EXP: begin
                coef = FIX_ONE;
            end

            // Odd terms only
            FUNC_SINH: begin
                if (idx[0]) begin
                    coef = FIX_ONE;
                end else begin
                    coef = FIX_ZERO;
                end
            end

            // Even terms only
            FUNC_COSH: begin
                if (idx[0]) begin
                    coef = FIX_ZERO;
                end else begin
                    coef = FIX_ONE;
                end
            end

            default: begin
                coef = FIX_ZERO;
            end
        endcase
    end

endmodule

// ==== hdl/taylor_pkg.sv ====
// Shared definitions for the Taylor series arithmetic unit
// Number format, function codes, sequencer steps and DSP slice operand bundles

package taylor_pkg;

    // ----------------------------------------
    // Number format
    // ----------------------------------------

    // Q2.16 signed fixed point
    typedef logic signed [17:0] fix18_t;

    localparam int unsigned FRAC_BITS = 16;

    localparam fix18_t FIX_ZERO    = 18'sh00000;
    localparam fix18_t FIX_ONE     = 18'sh10000;
    localparam fix18_t FIX_NEG_ONE = 18'sh30000;

    // Index into the term and coefficient tables
    typedef logic [3:0] term_idx_t;

    // Series terms after the constant one
    localparam int unsigned TERM_COUNT = 10;

    // ----------------------------------------
    // Function codes and micro-steps
    // ----------------------------------------

    typedef enum logic [2:0] {
        FUNC_SIN  = 3'd0,
        FUNC_COS  = 3'd1,
        FUNC_EXP  = 3'd2,
        FUNC_SINH = 3'd3,
        FUNC_COSH = 3'd4
    } func_sel_e;

    typedef enum logic [3:0] {
        STEP_INIT     = 4'd0,
        STEP_WAIT     = 4'd1,
        STEP_POWERS   = 4'd2,
        STEP_SEED     = 4'd3,
        STEP_SCALE    = 4'd4,
        STEP_ACCUM    = 4'd5,
        STEP_DRAIN    = 4'd6,
        STEP_LAST_ACC = 4'd7,
        STEP_SETTLE   = 4'd8,
        STEP_DONE     = 4'd9
    } seq_step_e;

    // Edge that samples do_calc to the rise of calc_done.
    // Powers, seed, scale/accumulate pairs, drain, last accumulate,
    // three settle cycles and the result move
    localparam int unsigned TAYLOR_LATENCY = TERM_COUNT + 1 + 2 * TERM_COUNT + 1 + 1 + 3 + 1;

    // ----------------------------------------
    // DSP slice operands
    // ----------------------------------------

    typedef enum logic [1:0] {
        XIN_ZERO = 2'd0,
        XIN_MULT = 2'd1
    } xin_sel_e;

    typedef enum logic [1:0] {
        ZIN_ZERO = 2'd0,
        ZIN_POUT = 2'd1
    } zin_sel_e;

    typedef struct packed {
        xin_sel_e xin_sel;
        zin_sel_e zin_sel;
        fix18_t   a;
        fix18_t   b;
    } dsp_in_t;

    typedef struct packed {
        logic signed [35:0] m;
        logic signed [47:0] p;
    } dsp_out_t;

endpackage

// ==== hdl/taylor_sequencer.sv ====
// Microcoded controller for the Taylor series unit
// Builds the x^n/n! term table on the shared DSP slice, then sums the
// terms weighted by the derivative coefficients and emits the result

`timescale 1ns/1ps

module taylor_sequencer import taylor_pkg::*; (
    input  logic      reset,
    input  logic      clk,
    input  logic      do_calc,
    input  func_sel_e func_sel,
    input  fix18_t    x_in,
    output logic      calc_done,
    output fix18_t    result,
    output dsp_in_t   dsp_in,
    input  dsp_out_t  dsp_out
);

    // ----------------------------------------
    // Micro-operation word
    // ----------------------------------------

    typedef enum logic [2:0] {
        MUL_NONE,
        MUL_X_RJ,       // x * 1/j into term j
        MUL_X_RJ_CLR,   // Same operands with the accumulator cleared
        MUL_VI_VJ,      // term i * term j into term j
        MUL_M_VJ,       // previous product * term j into term j
        MUL_VI_CI_ACC   // term i * coefficient i added to P
    } mul_op_e;

    typedef enum logic [1:0] {
        REP_NONE,
        REP_3,
        REP_10
    } rep_e;

    typedef struct packed {
        seq_step_e next;
        mul_op_e   mul_op;
        rep_e      repeat_n;
        logic      wait_in;
        logic      loop_j;
        logic      mov_v0_one;
        logic      mov_i_zero;
        logic      mov_j_one;
        logic      inc_i;
        logic      inc_j;
        logic      mov_res_ac;
    } micro_t;

    seq_step_e pc;
    micro_t    uop;
    term_idx_t i_reg;
    term_idx_t j_reg;
    logic [3:0] rep_cnt;
    logic [3:0] rep_max;
    logic       rep_hold;

    fix18_t    x_reg;
    func_sel_e func_reg;
    fix18_t    coef_i;
    fix18_t    recip_j;
    fix18_t    m_q;

    fix18_t    term_tab [0:TERM_COUNT];
    logic      wr_stb [0:1];
    term_idx_t wr_idx [0:1];

    // Q2.16 view of the slice outputs
    assign m_q = dsp_out.m[FRAC_BITS+17:FRAC_BITS];

    // Microcode program
    always_comb begin
        uop      = '0;
        uop.next = STEP_WAIT;
        case (pc)
            STEP_INIT: begin
                uop.mov_v0_one = 1'b1;
                uop.next       = STEP_WAIT;
            end
            STEP_WAIT: begin
                uop.wait_in   = 1'b1;
                uop.mov_j_one = 1'b1;
                uop.next      = STEP_POWERS;
            end
            STEP_POWERS: begin
                uop.repeat_n = REP_10;
                uop.mul_op   = MUL_X_RJ;
                uop.inc_j    = 1'b1;
                uop.next     = STEP_SEED;
            end
            STEP_SEED: begin
                uop.mul_op     = MUL_X_RJ_CLR;
                uop.mov_i_zero = 1'b1;
                uop.mov_j_one  = 1'b1;
                uop.next       = STEP_SCALE;
            end
            STEP_SCALE: begin
                uop.mul_op = (i_reg == '0) ? MUL_VI_VJ : MUL_M_VJ;
                uop.next   = STEP_ACCUM;
            end
            STEP_ACCUM: begin
                uop.mul_op = MUL_VI_CI_ACC;
                uop.inc_i  = 1'b1;
                uop.inc_j  = 1'b1;
                uop.loop_j = 1'b1;
                uop.next   = STEP_DRAIN;
            end
            STEP_DRAIN:    uop.next = STEP_LAST_ACC;
            STEP_LAST_ACC: begin
                uop.mul_op = MUL_VI_CI_ACC;
                uop.next   = STEP_SETTLE;
            end
            STEP_SETTLE: begin
                uop.repeat_n = REP_3;
                uop.next     = STEP_DONE;
            end
            STEP_DONE: begin
                uop.mov_res_ac = 1'b1;
                uop.next       = STEP_WAIT;
            end
            default:       uop.next = STEP_WAIT;
        endcase
    end

    // ----------------------------------------
    // Program counter and repeat counter
    // ----------------------------------------

    always_comb begin
        case (uop.repeat_n)
            REP_3:   rep_max = 4'd2;
            REP_10:  rep_max = 4'd9;
            default: rep_max = 4'd0;
        endcase
    end

    assign rep_hold = (rep_cnt != rep_max);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pc      <= STEP_INIT;
            rep_cnt <= 4'd0;
        end else begin
            if (rep_hold) begin
                rep_cnt <= rep_cnt + 4'd1;
            end else begin
                rep_cnt <= 4'd0;
            end

            if ((uop.wait_in && !do_calc) || rep_hold) begin
                pc <= pc;
            end else if (uop.loop_j && (j_reg != term_idx_t'(TERM_COUNT))) begin
                pc <= STEP_SCALE;
            end else begin
                pc <= uop.next;
            end
        end
    end

    // Index registers
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            i_reg <= '0;
            j_reg <= '0;
        end else begin
            if (uop.mov_i_zero) begin
                i_reg <= '0;
            end else if (uop.inc_i) begin
                i_reg <= i_reg + term_idx_t'(1);
            end

            if (uop.mov_j_one) begin
                j_reg <= term_idx_t'(1);
            end else if (uop.inc_j) begin
                j_reg <= j_reg + term_idx_t'(1);
            end
        end
    end

    // Argument and function latched on an accepted request
    always_ff @(posedge reset) begin
        if (uop.wait_in && do_calc) begin
            x_reg    <= x_in;
            func_reg <= func_sel;
        end
    end

    // ----------------------------------------
    // Operand selection
    // ----------------------------------------

    taylor_coef_rom coef_rom_i (
        .func_sel (func_reg),
        .idx      (i_reg),
        .coef     (coef_i)
    );

    // 1/j in Q2.16
    always_comb begin
        case (j_reg)
            4'd1:    recip_j = 18'sh10000;
            4'd2:    recip_j = 18'sh08000;
            4'd3:    recip_j = 18'sh05555;
            4'd4:    recip_j = 18'sh04000;
            4'd5:    recip_j = 18'sh03333;
            4'd6:    recip_j = 18'sh02aab;
            4'd7:    recip_j = 18'sh02492;
            4'd8:    recip_j = 18'sh02000;
            4'd9:    recip_j = 18'sh01c72;
            4'd10:   recip_j = 18'sh0199a;
            default: recip_j = FIX_ZERO;
        endcase
    end

    always_comb begin
        dsp_in.xin_sel = XIN_ZERO;
        dsp_in.zin_sel = ZIN_POUT;
        dsp_in.a       = FIX_ZERO;
        dsp_in.b       = FIX_ZERO;
        case (uop.mul_op)
            MUL_X_RJ: begin
                dsp_in.a = x_reg;
                dsp_in.b = recip_j;
            end
            MUL_X_RJ_CLR: begin
                dsp_in.zin_sel = ZIN_ZERO;
                dsp_in.a       = x_reg;
                dsp_in.b       = recip_j;
            end
            MUL_VI_VJ: begin
                dsp_in.a = term_tab[i_reg];
                dsp_in.b = term_tab[j_reg];
            end
            MUL_M_VJ: begin
                dsp_in.a = m_q;
                dsp_in.b = term_tab[j_reg];
            end
            MUL_VI_CI_ACC: begin
                dsp_in.xin_sel = XIN_MULT;
                dsp_in.a       = term_tab[i_reg];
                dsp_in.b       = coef_i;
            end
            default: begin
                dsp_in.a = FIX_ZERO;
            end
        endcase
    end

    // ----------------------------------------
    // Term table write-back
    // ----------------------------------------

    // Product lands in M two edges after issue
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_stb[0] <= 1'b0;
            wr_stb[1] <= 1'b0;
            wr_idx[0] <= '0;
            wr_idx[1] <= '0;
        end else begin
            wr_stb[0] <= (uop.mul_op == MUL_X_RJ) || (uop.mul_op == MUL_VI_VJ) ||
                         (uop.mul_op == MUL_M_VJ);
            wr_stb[1] <= wr_stb[0];
            wr_idx[0] <= j_reg;
            wr_idx[1] <= wr_idx[0];
        end
    end

    always_ff @(posedge reset) begin
        if (uop.mov_v0_one) begin
            term_tab[0] <= FIX_ONE;
        end else if (wr_stb[1]) begin
            term_tab[wr_idx[1]] <= m_q;
        end
    end

    // Result pulse that stays zero outside the done cycle
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            calc_done <= 1'b0;
            result    <= FIX_ZERO;
        end else if (uop.mov_res_ac) begin
            calc_done <= 1'b1;
            result    <= dsp_out.p[FRAC_BITS+17:FRAC_BITS];
        end else begin
            calc_done <= 1'b0;
            result    <= FIX_ZERO;
        end
    end

endmodule

// ==== hdl/taylor_unit.sv ====
// Top level of the Taylor series arithmetic unit
// Sequencer and shared multiply-accumulate slice side by side

`timescale 1ns/1ps

module taylor_unit import taylor_pkg::*; (
    input  logic      reset,
    input  logic      clk,
    input  logic      do_calc,
    input  func_sel_e func_sel,
    input  fix18_t    x_in,
    output logic      calc_done,
    output fix18_t    result
);

    // Slice operand and result bundles
    dsp_in_t  dsp_in;
    dsp_out_t dsp_out;

    taylor_sequencer sequencer_i (
        .reset     (reset),
        .clk       (clk),
        .do_calc   (do_calc),
        .func_sel  (func_sel),
        .x_in      (x_in),
        .calc_done (calc_done),
        .result    (result),
        .dsp_in    (dsp_in),
        .dsp_out   (dsp_out)
    );

    dsp_mac_slice mac_i (
        .reset   (reset),
        .clk     (clk),
        .dsp_in  (dsp_in),
        .dsp_out (dsp_out)
    );

endmodule

// ==== verification/taylor_testdata.txt ====
// func x expected, all hex; func 0 sin, 1 cos, 2 exp, 3 sinh, 4 cosh
// x and expected are Q2.16 in 18 bits, truncating series arithmetic
0 00000 00000
1 00000 10000
2 00000 10000
3 00000 00000
4 00000 10000
0 08000 07abb
1 08000 0e0a9
2 08000 1a610
3 08000 08565
4 08000 120ab
0 38000 38545
1 38000 0e0a9
2 38000 09b42
3 38000 37a97
4 38000 120ab
0 18000 0ff5d
1 18000 0121c

// ==== verification/taylor_checks.svh ====
// Compare tasks for the Taylor unit testbench
// Included into taylor_unit_tb and used on calc_done and result

`ifndef TAYLOR_CHECKS_SVH
`define TAYLOR_CHECKS_SVH

// ----------------------------------------
// Failure exit
// ----------------------------------------

task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped");
endtask

// ----------------------------------------
// Typed comparisons
// ----------------------------------------

// Q2.16 result word
task automatic compare_result(input string name, input fix18_t expected,
                              input fix18_t actual);
    if (actual !== expected) begin
        $display("mismatch %s: result expected %05h, actual %05h",
                 name, expected, actual);
        stop_run("result word differs from the expected value");
    end
endtask

// Done strobe level against the expected cycle
task automatic compare_done(input string name, input logic expected,
                            input logic actual);
    if (actual !== expected) begin
        $display("mismatch %s: calc_done expected %b, actual %b",
                 name, expected, actual);
        stop_run("calc_done has the wrong level");
    end
endtask

// Outputs while no result is due
task automatic check_idle(input string name);
    compare_done(name, 1'b0, calc_done);
    compare_result(name, FIX_ZERO, result);
endtask

`endif

// ==== verification/taylor_unit_tb.sv ====
// Testbench for the Taylor series unit
// Replays the vectors of the test data file, checks values, pulse shape
// and latency, and throws ignored strobes into the busy periods

`timescale 1ns/1ps

module taylor_unit_tb import taylor_pkg::*; ();

    localparam int NUM_VEC    = 17;
    localparam int WAIT_LIMIT = TAYLOR_LATENCY + 10;

    // Port reset carries the clock and clk the asynchronous reset
    logic      reset;
    logic      clk;
    logic      do_calc;
    func_sel_e func_sel;
    fix18_t    x_in;
    logic      calc_done;
    fix18_t    result;

    // Three words per vector for the function, argument and expected result
    logic [17:0] vec_mem [0:3*NUM_VEC-1];
    int          seed;

    `include "taylor_checks.svh"

    always #50 reset = ~reset;

    taylor_unit dut_i (
        .reset     (reset),
        .clk       (clk),
        .do_calc   (do_calc),
        .func_sel  (func_sel),
        .x_in      (x_in),
        .calc_done (calc_done),
        .result    (result)
    );

    // Outputs are settled and inputs change here
    task automatic step_cycle();
        @(posedge reset);
        #1;
    endtask

    task automatic idle_cycles(input int n, input string name);
        repeat (n) begin
            step_cycle();
            check_idle(name);
        end
    endtask

    // ----------------------------------------
    // One request with junk strobes while busy
    // ----------------------------------------

    task automatic run_vector(input int v, input string name);
        func_sel_e   f;
        fix18_t      x;
        fix18_t      expected;
        int          count;
        int          junk_at;
        int          rnd;
        logic [7:0]  junk_func;
        logic        done_seen;
        f        = func_sel_e'(vec_mem[3*v][2:0]);
        x        = vec_mem[3*v+1];
        expected = vec_mem[3*v+2];
        if ($isunknown(vec_mem[3*v+2])) begin
            stop_run($sformatf("test data file has no entry for %s", name));
        end
        // Junk strobe lands anywhere in the busy period
        rnd     = $random(seed);
        junk_at = 1 + int'($unsigned(rnd) % (TAYLOR_LATENCY - 1));

        do_calc  = 1'b1;
        func_sel = f;
        x_in     = x;
        step_cycle();
        do_calc = 1'b0;
        check_idle(name);

        count     = 0;
        done_seen = 1'b0;
        while (!done_seen && count < WAIT_LIMIT) begin
            step_cycle();
            count++;
            compare_done(name, (count == TAYLOR_LATENCY), calc_done);
            if (calc_done) begin
                done_seen = 1'b1;
            end else begin
                compare_result(name, FIX_ZERO, result);
            end
            // Strobe with other operands that the DUT must ignore
            if (count == junk_at) begin
                rnd       = $random(seed);
                junk_func = rnd[7:0] % 8'd5;
                do_calc   = 1'b1;
                func_sel  = func_sel_e'(junk_func[2:0]);
                x_in      = rnd[25:8];
            end else if (count == junk_at + 1) begin
                do_calc = 1'b0;
            end
        end
        if (!done_seen) begin
            stop_run($sformatf("calc_done never came for %s", name));
        end
        compare_result(name, expected, result);
    endtask

    initial begin
        int    gap;
        string name;
        seed     = 32'hf8bd;
        reset    = 1'b0;
        clk      = 1'b1;
        do_calc  = 1'b0;
        func_sel = FUNC_SIN;
        x_in     = FIX_ZERO;
        $readmemh("verification/taylor_testdata.txt", vec_mem);

        // Outputs stay quiet through reset
        idle_cycles(8, "reset");
        clk = 1'b0;
        idle_cycles(3, "after reset");

        for (int v = 0; v < NUM_VEC; v++) begin
            name = $sformatf("vector %0d", v);
            // Every fourth request follows the done pulse directly
            if (v % 4 != 3) begin
                gap = 1 + ($random(seed) & 3);
                idle_cycles(gap, name);
            end
            run_vector(v, name);
        end
        idle_cycles(4, "final idle");

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verification
hdl/taylor_pkg.sv
hdl/taylor_coef_rom.sv
hdl/dsp_mac_slice.sv
hdl/taylor_sequencer.sv
hdl/taylor_unit.sv
verification/taylor_unit_tb.sv
